/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // byte lanes per word
  localparam int LANES = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // wmask bit 0 covers wdata[7:0]
  typedef struct packed {
    logic             write;
    addr_t            addr;
    data_t            wdata;
    logic [LANES-1:0] wmask;
  } bus_req_t;

  // err set when no bank decoded the address
  typedef struct packed {
    logic  err;
    data_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
  parameter integer DEPTH     = 4,
  parameter type    payload_t = logic
) (
  input  logic     clk,
  input  logic     i_rst,

  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,

  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data,

  output logic     o_almost_full
);

  localparam integer PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam integer CNT_W = $clog2(DEPTH + 1);

  payload_t         buf_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_ready       = (count != CNT_W'(DEPTH));
  assign o_valid       = (count != '0);
  assign o_almost_full = (count >= CNT_W'(DEPTH - 1));
  assign o_data        = buf_mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      buf_mem[wr_ptr] <= i_data;
    end
  end

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (i_rst) count <= CNT_W'(DEPTH))
    else $error("stream_fifo: count above depth");

endmodule

`default_nettype wire

/* mem.sv */
`timescale 1ns/10ps
`default_nettype none

module mem
  import mem_pkg::*;
#(
  parameter integer SIZE      = 8,
  parameter addr_t  ADDR_BASE = 32'h0000_0000
) (
  input  logic     clk,

  input  logic     i_fetch_req,
  input  addr_t    i_fetch_addr,
  output logic     o_fetch_ack,
  output data_t    o_fetch_data,

  input  logic     i_bus_req,
  input  bus_req_t i_bus,
  output logic     o_bus_ack,
  output data_t    o_bus_data
);

  localparam integer IDX_W    = SIZE - 2;
  localparam integer WORDS    = 2 ** IDX_W;
  localparam addr_t  WIN_LAST = ADDR_BASE + addr_t'(2 ** SIZE - 1);

  logic             fetch_hit;
  logic             bus_hit;
  addr_t            fetch_off;
  addr_t            bus_off;
  logic [IDX_W-1:0] fetch_idx;
  logic [IDX_W-1:0] bus_idx;

  // window decode for both ports
  assign fetch_hit = i_fetch_req && (i_fetch_addr >= ADDR_BASE) && (i_fetch_addr <= WIN_LAST);
  assign bus_hit   = i_bus_req && (i_bus.addr >= ADDR_BASE) && (i_bus.addr <= WIN_LAST);

  assign fetch_off = i_fetch_addr - ADDR_BASE;
  assign bus_off   = i_bus.addr - ADDR_BASE;
  assign fetch_idx = fetch_off[SIZE-1:2];
  assign bus_idx   = bus_off[SIZE-1:2];

  always_ff @(posedge clk)
  begin
    o_fetch_ack <= fetch_hit;
    o_bus_ack   <= bus_hit;
  end

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    logic [7:0] lane_mem [WORDS];
    logic [7:0] fetch_byte;
    logic [7:0] bus_byte;

    // read returns the byte as it was before a write in the same cycle
    always_ff @(posedge clk)
    begin
      if (bus_hit && i_bus.write && i_bus.wmask[g])
      begin
        lane_mem[bus_idx] <= i_bus.wdata[8*g +: 8];
      end
      bus_byte   <= bus_hit ? lane_mem[bus_idx] : 8'h00;
      fetch_byte <= fetch_hit ? lane_mem[fetch_idx] : 8'h00;
    end

    assign o_fetch_data[8*g +: 8] = fetch_byte;
    assign o_bus_data[8*g +: 8]   = bus_byte;
  end

  // acks only ever answer a request from the previous cycle
  a_bus_ack_follows_req: assert property (@(posedge clk) o_bus_ack |-> $past(i_bus_req))
    else $error("mem: bus ack without request");
  a_fetch_ack_follows_req: assert property (@(posedge clk) o_fetch_ack |-> $past(i_fetch_req))
    else $error("mem: fetch ack without request");

endmodule

`default_nettype wire

/* membus_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module membus_bridge
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     i_rst,

  input  logic     i_cmd_valid,
  output logic     o_cmd_ready,
  input  bus_req_t i_cmd,

  input  logic     i_rsp_almost_full,
  output logic     o_rsp_valid,
  output bus_rsp_t o_rsp,

  output logic     o_bus_req,
  output bus_req_t o_bus,

  input  logic     i_bus_ack0,
  input  data_t    i_bus_data0,
  input  logic     i_bus_ack1,
  input  data_t    i_bus_data1
);

  logic issue;
  logic pending;
  logic any_ack;

  // two free slots needed since the access in flight may claim one
  assign o_cmd_ready = !i_rsp_almost_full;
  assign issue       = i_cmd_valid && o_cmd_ready;

  assign o_bus_req = issue;
  assign o_bus     = i_cmd;

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      pending <= 1'b0;
    end
    else
    begin
      pending <= issue;
    end
  end

  // the bank outside its window returns zero, so OR merges cleanly
  assign any_ack     = i_bus_ack0 || i_bus_ack1;
  assign o_rsp_valid = pending;
  assign o_rsp.err   = !any_ack;
  assign o_rsp.rdata = i_bus_data0 | i_bus_data1;

  // bank windows must not overlap
  a_single_ack: assert property (@(posedge clk) disable iff (i_rst)
      !(i_bus_ack0 && i_bus_ack1))
    else $error("membus_bridge: both banks acknowledged");
  a_ack_needs_pending: assert property (@(posedge clk) disable iff (i_rst)
      any_ack |-> pending)
    else $error("membus_bridge: ack without pending request");

endmodule

`default_nettype wire

/* mem_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys
  import mem_pkg::*;
#(
  parameter integer MEM_SIZE   = 8,
  parameter addr_t  BASE0      = 32'h0000_0000,
  parameter addr_t  BASE1      = 32'h0000_1000,
  parameter integer FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     i_rst,

  input  logic     i_req_valid,
  output logic     o_req_ready,
  input  bus_req_t i_req,

  output logic     o_rsp_valid,
  input  logic     i_rsp_ready,
  output bus_rsp_t o_rsp,

  input  logic     i_fetch_req,
  input  addr_t    i_fetch_addr,
  output logic     o_fetch_ack,
  output data_t    o_fetch_data
);

  logic     cmd_valid;
  logic     cmd_ready;
  bus_req_t cmd;
  logic     rsp_push;
  logic     rsp_room;
  logic     rsp_almost_full;
  bus_rsp_t rsp_in;
  logic     bus_req;
  bus_req_t bus;
  logic     bus_ack0;
  logic     bus_ack1;
  data_t    bus_data0;
  data_t    bus_data1;
  logic     fetch_ack0;
  logic     fetch_ack1;
  data_t    fetch_data0;
  data_t    fetch_data1;

  stream_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (bus_req_t)
  ) u_cmd_fifo (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_valid       (i_req_valid),
    .o_ready       (o_req_ready),
    .i_data        (i_req),
    .o_valid       (cmd_valid),
    .i_ready       (cmd_ready),
    .o_data        (cmd),
    .o_almost_full ()
  );

  membus_bridge u_bridge (
    .clk               (clk),
    .i_rst             (i_rst),
    .i_cmd_valid       (cmd_valid),
    .o_cmd_ready       (cmd_ready),
    .i_cmd             (cmd),
    .i_rsp_almost_full (rsp_almost_full),
    .o_rsp_valid       (rsp_push),
    .o_rsp             (rsp_in),
    .o_bus_req         (bus_req),
    .o_bus             (bus),
    .i_bus_ack0        (bus_ack0),
    .i_bus_data0       (bus_data0),
    .i_bus_ack1        (bus_ack1),
    .i_bus_data1       (bus_data1)
  );

  stream_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (bus_rsp_t)
  ) u_rsp_fifo (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_valid       (rsp_push),
    .o_ready       (rsp_room),
    .i_data        (rsp_in),
    .o_valid       (o_rsp_valid),
    .i_ready       (i_rsp_ready),
    .o_data        (o_rsp),
    .o_almost_full (rsp_almost_full)
  );

  mem #(
    .SIZE      (MEM_SIZE),
    .ADDR_BASE (BASE0)
  ) u_bank0 (
    .clk          (clk),
    .i_fetch_req  (i_fetch_req),
    .i_fetch_addr (i_fetch_addr),
    .o_fetch_ack  (fetch_ack0),
    .o_fetch_data (fetch_data0),
    .i_bus_req    (bus_req),
    .i_bus        (bus),
    .o_bus_ack    (bus_ack0),
    .o_bus_data   (bus_data0)
  );

  mem #(
    .SIZE      (MEM_SIZE),
    .ADDR_BASE (BASE1)
  ) u_bank1 (
    .clk          (clk),
    .i_fetch_req  (i_fetch_req),
    .i_fetch_addr (i_fetch_addr),
    .o_fetch_ack  (fetch_ack1),
    .o_fetch_data (fetch_data1),
    .i_bus_req    (bus_req),
    .i_bus        (bus),
    .o_bus_ack    (bus_ack1),
    .o_bus_data   (bus_data1)
  );

  // idle bank drives zero data
  assign o_fetch_ack  = fetch_ack0 || fetch_ack1;
  assign o_fetch_data = fetch_data0 | fetch_data1;

  // unchecked bridge push relies on the almost-full throttle
  a_rsp_push_room: assert property (@(posedge clk) disable iff (i_rst) rsp_push |-> rsp_room)
    else $error("mem_subsys: response pushed into a full FIFO");

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam integer MEM_SIZE   = 8;
  localparam addr_t  BASE0      = 32'h0000_0000;
  localparam addr_t  BASE1      = 32'h0000_1000;
  localparam integer FIFO_DEPTH = 4;
  localparam integer BANK_BYTES = 2 ** MEM_SIZE;
  localparam integer WORDS      = BANK_BYTES / 4;
  localparam integer TIMEOUT    = 100;

  logic     clk = 1'b0;
  logic     i_rst;
  logic     i_req_valid;
  logic     o_req_ready;
  bus_req_t i_req;
  logic     o_rsp_valid;
  logic     i_rsp_ready;
  bus_rsp_t o_rsp;
  logic     i_fetch_req;
  addr_t    i_fetch_addr;
  logic     o_fetch_ack;
  data_t    o_fetch_data;

  // byte model per bank
  logic [7:0] model [2][BANK_BYTES];
  // set once a byte has been written
  bit         known [2][BANK_BYTES];
  bus_rsp_t   exp_q [$];
  bit         chk_q [$];
  int         errors;
  int         timeouts;

  always #5 clk = ~clk;

  mem_subsys #(
    .MEM_SIZE   (MEM_SIZE),
    .BASE0      (BASE0),
    .BASE1      (BASE1),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req        (i_req),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp        (o_rsp),
    .i_fetch_req  (i_fetch_req),
    .i_fetch_addr (i_fetch_addr),
    .o_fetch_ack  (o_fetch_ack),
    .o_fetch_data (o_fetch_data)
  );

  function automatic int bank_of(input addr_t a);
    if (a >= BASE0 && a < BASE0 + addr_t'(BANK_BYTES))
      return 0;
    if (a >= BASE1 && a < BASE1 + addr_t'(BANK_BYTES))
      return 1;
    return -1;
  endfunction

  function automatic int first_byte(input addr_t a, input int b);
    addr_t off;
    off = a - ((b == 1) ? BASE1 : BASE0);
    return int'(off[MEM_SIZE-1:2]) * 4;
  endfunction

  function automatic data_t model_word(input int b, input int base);
    data_t w;
    int    l;
    for (l = 0; l < 4; l++)
      w[8*l +: 8] = model[b][base + l];
    return w;
  endfunction

  function automatic addr_t rand_addr(input int b);
    return ((b == 1) ? BASE1 : BASE0) + addr_t'(($urandom % WORDS) * 4);
  endfunction

  task automatic log_mismatch(input string what, input data_t got, input data_t exp);
    errors++;
    $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic send_req(input logic write, input addr_t addr, input data_t wdata,
                          input logic [3:0] mask);
    int       waited;
    int       b;
    int       base;
    int       l;
    bit       ok;
    bus_rsp_t exp;
    i_req_valid = 1'b1;
    i_req       = '{write: write, addr: addr, wdata: wdata, wmask: mask};
    waited      = 0;
    while (!o_req_ready && waited < TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!o_req_ready)
    begin
      $display("Timeout: request stream never became ready at %0t", $time);
      timeouts++;
    end
    else
    begin
      // transfer happens on the rising edge in between
      @(negedge clk);
      b         = bank_of(addr);
      exp.err   = (b < 0);
      exp.rdata = '0;
      ok        = 1'b1;
      if (b >= 0)
      begin
        base      = first_byte(addr, b);
        exp.rdata = model_word(b, base);
        for (l = 0; l < 4; l++)
        begin
          ok = ok && known[b][base + l];
          if (write && mask[l])
          begin
            model[b][base + l] = wdata[8*l +: 8];
            known[b][base + l] = 1'b1;
          end
        end
      end
      exp_q.push_back(exp);
      chk_q.push_back(ok);
    end
    i_req_valid = 1'b0;
  endtask

  task automatic get_rsp();
    int       waited;
    bus_rsp_t exp;
    bit       ok;
    i_rsp_ready = 1'b1;
    waited      = 0;
    while (!o_rsp_valid && waited < TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!o_rsp_valid)
    begin
      $display("Timeout: no response arrived at %0t", $time);
      timeouts++;
    end
    else if (exp_q.size() == 0)
    begin
      $display("A response arrived with no request outstanding at %0t", $time);
      errors++;
      @(negedge clk);
    end
    else
    begin
      exp = exp_q.pop_front();
      ok  = chk_q.pop_front();
      assert (o_rsp.err == exp.err)
        else log_mismatch("rsp err", data_t'(o_rsp.err), data_t'(exp.err));
      // bytes never written have no predicted value
      if (ok)
      begin
        assert (o_rsp.rdata == exp.rdata)
          else log_mismatch("rsp rdata", o_rsp.rdata, exp.rdata);
      end
      @(negedge clk);
    end
    i_rsp_ready = 1'b0;
  endtask

  task automatic fetch(input addr_t addr);
    int    b;
    data_t exp;
    b   = bank_of(addr);
    exp = (b >= 0) ? model_word(b, first_byte(addr, b)) : '0;
    i_fetch_req  = 1'b1;
    i_fetch_addr = addr;
    @(negedge clk);
    i_fetch_req = 1'b0;
    assert (o_fetch_ack == (b >= 0))
      else log_mismatch("fetch ack", data_t'(o_fetch_ack), data_t'(b >= 0));
    assert (o_fetch_data == exp)
      else log_mismatch("fetch data", o_fetch_data, exp);
  endtask

  task automatic reset_state_check();
    assert (!o_rsp_valid)
      else log_mismatch("o_rsp_valid after reset", data_t'(o_rsp_valid), '0);
    assert (!o_fetch_ack)
      else log_mismatch("o_fetch_ack after reset", data_t'(o_fetch_ack), '0);
    assert (o_req_ready)
      else log_mismatch("o_req_ready after reset", data_t'(o_req_ready), 32'h1);
  endtask

  task automatic fill_banks();
    int    w;
    addr_t a;
    for (w = 0; w < 2 * WORDS; w++)
    begin
      a = ((w < WORDS) ? BASE0 : BASE1) + addr_t'((w % WORDS) * 4);
      send_req(1'b1, a, a ^ 32'hA5C3_5A3C, 4'hF);
      get_rsp();
    end
  endtask

  task automatic word_and_mask_rw(input bit partial);
    int         i;
    addr_t      a;
    logic [3:0] m;
    for (i = 0; i < 8; i++)
    begin
      a = rand_addr(i % 2);
      m = partial ? 4'($urandom) : 4'hF;
      send_req(1'b1, a, $urandom, m);
      get_rsp();
      send_req(1'b0, a, '0, 4'h0);
      get_rsp();
    end
  endtask

  task automatic unmapped_access();
    send_req(1'b1, BASE0 + addr_t'(BANK_BYTES + 4), $urandom, 4'hF);
    get_rsp();
    send_req(1'b1, BASE1 + addr_t'(BANK_BYTES + 4), $urandom, 4'hF);
    get_rsp();
    send_req(1'b0, 32'hFFFF_FFF0, '0, 4'h0);
    get_rsp();
    // same offset inside each window must be untouched
    send_req(1'b0, BASE0 + 32'h4, '0, 4'h0);
    get_rsp();
    send_req(1'b0, BASE1 + 32'h4, '0, 4'h0);
    get_rsp();
  endtask

  task automatic fetch_port_check();
    int i;
    for (i = 0; i < 6; i++)
      fetch(rand_addr(i % 2));
    fetch(BASE0 + addr_t'(BANK_BYTES));
    fetch(32'h8000_0000);
  endtask

  task automatic backpressure_drain();
    int    sent;
    addr_t a;
    sent        = 0;
    i_rsp_ready = 1'b0;
    while (o_req_ready && sent < 2 * FIFO_DEPTH && timeouts == 0)
    begin
      // a few shared words so a reordered response shows up as wrong data
      a = ((sent % 2) ? BASE1 : BASE0) + addr_t'(((sent / 2) % 2) * 4);
      send_req(sent % 3 != 2, a, $urandom, 4'hF);
      sent++;
    end
    assert (!o_req_ready)
      else log_mismatch("o_req_ready under back-pressure", data_t'(o_req_ready), '0);
    while (exp_q.size() > 0 && timeouts == 0)
      get_rsp();
  endtask

  initial
  begin
    errors       = 0;
    timeouts     = 0;
    void'($urandom(20413));
    i_rst        = 1'b1;
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_rsp_ready  = 1'b0;
    i_fetch_req  = 1'b0;
    i_fetch_addr = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    reset_state_check();
    fill_banks();
    if (timeouts == 0)
      word_and_mask_rw(1'b0);
    if (timeouts == 0)
      word_and_mask_rw(1'b1);
    if (timeouts == 0)
      unmapped_access();
    if (timeouts == 0)
      fetch_port_check();
    if (timeouts == 0)
      backpressure_drain();

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
mem_pkg.sv
stream_fifo.sv
mem.sv
membus_bridge.sv
mem_subsys.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
LINT_TOP  ?= mem_subsys
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Verification passed

SRCS := $(wildcard *.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
